/* project.f */
+incdir+.
obj_pkg.sv
obj_ram.sv
obj_scan.sv
obj_line_buffer.sv
obj_top.sv
obj_checker.sv
obj_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module obj_tb -f project.f

# keep running past assertion errors so the testbench prints its verdict
output=$(./obj_dir/Vobj_tb +verilator+error+limit+1000 || true)
echo "$output"
echo "$output" | grep -qx "TEST PASS"

/* obj_tb.sv */
`include "obj_cfg.svh"

module obj_tb;

    localparam logic [31:0] SEED = 32'h23d4003f;
    localparam int TBL_BYTES = 5 * `OBJ_COUNT;
    localparam int BLANK_LINE = 300;    // below every object

    logic                       clk;
    logic                       rst = 1'b1;
    logic                       cpu_we = 1'b0;
    logic [`OBJ_TABLE_AW-1:0]   cpu_addr = '0;
    logic [7:0]                 cpu_din = '0;
    logic                       lhbl = 1'b0;
    logic                       lvbl = 1'b1;
    logic [8:0]                 vrender = '0;
    logic [`OBJ_LINE_AW-1:0]    hdump = '0;
    logic                       pxl_cen = 1'b0;
    logic                       rom_ok = 1'b0;
    logic [15:0]                rom_data = '0;
    logic                       done;
    logic                       rom_cs;
    logic [`OBJ_ROM_AW-1:0]     rom_addr;
    logic [7:0]                 pxl;

    logic [7:0]                 tbl [TBL_BYTES];    // image of the attribute table
    obj_pkg::obj_attr_t         objs [`OBJ_COUNT];
    logic [7:0]                 ref_line [512];
    logic [31:0]                lat_state = SEED;
    logic [31:0]                obj_state = SEED;
    int                         lat_cnt = 0;
    int                         tests = 0;
    int                         checks = 0;
    int                         errors = 0;

    obj_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] obj_rand();
        obj_state = lcg_next(obj_state);
        return obj_state[31:16];
    endfunction

    // ROM contents are a hash of the word address
    function automatic logic [15:0] rom_word(input logic [`OBJ_ROM_AW-1:0] addr);
        logic [31:0] h;
        h = lcg_next(lcg_next(SEED ^ 32'(addr)));
        return h[31:16];
    endfunction

    // ROM model, 1 to 6 cycles per request
    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (lat_cnt == 0) begin
                lat_state = lcg_next(lat_state);
                lat_cnt = 1 + int'(lat_state[31:16] % 16'd6);
            end
            lat_cnt = lat_cnt - 1;
            if (lat_cnt == 0) begin
                rom_ok = 1'b1;
                rom_data = rom_word(rom_addr);
            end
        end
    end

    task automatic check_pixel(input int col, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED pxl at hdump %0d: got %h expected %h", col, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_attr(input int n, input obj_pkg::obj_attr_t got,
                              input obj_pkg::obj_attr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED attr[%0d]: got %h expected %h", n, got, exp);
        end
    endtask

    task automatic set_obj(input int n, input obj_pkg::obj_attr_t a);
        objs[n] = a;
        tbl[5*n]   = {a.code[13:12], a.vflip, a.hflip, 2'b00, a.size16, a.x[8]};
        tbl[5*n+1] = a.y;
        tbl[5*n+2] = a.code[9:2];
        tbl[5*n+3] = {a.pal, 2'b00, a.code[11:10]};
        tbl[5*n+4] = a.x[7:0];
    endtask

    function automatic obj_pkg::obj_attr_t decode_entry(input int n);
        obj_pkg::obj_attr_t a;
        a = '0;
        a.x      = {tbl[5*n][0], tbl[5*n+4]};
        a.size16 = tbl[5*n][1];
        a.hflip  = tbl[5*n][4];
        a.vflip  = tbl[5*n][5];
        a.y      = tbl[5*n+1];
        a.code   = {tbl[5*n][7:6], tbl[5*n+3][1:0], tbl[5*n+2], 2'b00};
        a.pal    = tbl[5*n+3][7:4];
        return a;
    endfunction

    task automatic clear_objs();
        obj_pkg::obj_attr_t a;
        a = '0;
        a.y = 8'd240;   // parked below the test lines
        for (int n = 0; n < `OBJ_COUNT; n++) set_obj(n, a);
    endtask

    task automatic load_table();
        for (int i = 0; i < TBL_BYTES; i++) begin
            @(negedge clk);
            cpu_we = 1'b1;
            cpu_addr = `OBJ_TABLE_AW'(i);
            cpu_din = tbl[i];
        end
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    // expected line straight from the table bytes and the ROM hash
    task automatic render_line(input int line);
        obj_pkg::obj_attr_t a;
        int size;
        int r;
        int col;
        logic [13:0] code;
        logic [3:0] nib;
        foreach (ref_line[h]) ref_line[h] = 8'd0;
        for (int n = 0; n < `OBJ_COUNT; n++) begin
            a = decode_entry(n);
            check_attr(n, a, objs[n]);
            size = a.size16 ? 16 : 8;
            if (line >= int'(a.y) && line < int'(a.y) + size) begin
                r = a.vflip ? size - 1 - (line - int'(a.y)) : line - int'(a.y);
                for (int s = 0; s < size; s++) begin
                    code = a.code;
                    if (a.size16) code[1:0] = {r[3], s[3]};
                    nib = 4'(rom_word({code, r[2:0], s[2]}) >> (12 - 4 * (s % 4)));
                    col = int'(a.x) + `OBJ_X_OFFSET + (a.hflip ? size - 1 - s : s);
                    if (nib != 4'd0) ref_line[col % 512] = {a.pal, nib};
                end
            end
        end
    endtask

    task automatic line_start(input int line);
        @(negedge clk);
        vrender = 9'(line);
        lhbl = 1'b1;
        @(negedge clk);
        lhbl = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < 5000) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("timeout: done did not rise after a line start");
            $display("TEST FAIL");
            $finish;
        end
    endtask

    task automatic sweep_line();
        for (int h = 0; h < 512; h++) begin
            @(negedge clk);
            hdump = `OBJ_LINE_AW'(h);
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            check_pixel(h, pxl, ref_line[h]);
        end
    endtask

    // draw one line, then display it while a blank line is scanned
    task automatic run_line(input int line);
        line_start(line);
        wait_done();
        line_start(BLANK_LINE);
        render_line(line);
        sweep_line();
        wait_done();
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_flag("done", done, 1'b1);
        check_flag("rom_cs", rom_cs, 1'b0);
        foreach (ref_line[h]) ref_line[h] = 8'd0;
        sweep_line();
        report("reset", e);
    endtask

    task automatic test_single();
        obj_pkg::obj_attr_t a;
        int e;
        e = errors;
        clear_objs();
        a = '0;
        a.y = 8'd50;
        a.x = 9'd100;
        a.code = 14'h0124;
        a.pal = 4'h5;
        set_obj(0, a);
        load_table();
        run_line(53);
        run_line(70);   // not covered
        report("single", e);
    endtask

    task automatic test_flips();
        obj_pkg::obj_attr_t a;
        int e;
        e = errors;
        clear_objs();
        for (int k = 0; k < 4; k++) begin
            a = '0;
            a.y = 8'd80;
            a.x = 9'(20 + 40 * k);
            a.size16 = 1'b1;
            a.hflip = k[0];
            a.vflip = k[1];
            a.code = 14'(16'h0200 + 16'(8 * k));
            a.pal = 4'(k + 1);
            set_obj(k, a);
        end
        load_table();
        run_line(83);
        run_line(92);
        report("flips", e);
    endtask

    task automatic test_overlap();
        obj_pkg::obj_attr_t a;
        int e;
        e = errors;
        clear_objs();
        a = '0;
        a.y = 8'd120;
        a.x = 9'd200;
        a.size16 = 1'b1;
        a.code = 14'h0400;
        a.pal = 4'h3;
        set_obj(0, a);
        a.y = 8'd118;
        a.x = 9'd206;
        a.code = 14'h0a10;
        a.pal = 4'h9;
        set_obj(1, a);  // drawn last, on top
        load_table();
        run_line(125);
        report("overlap", e);
    endtask

    task automatic test_erase();
        int e;
        e = errors;
        foreach (ref_line[h]) ref_line[h] = 8'd0;
        sweep_line();   // same half again, already read once
        clear_objs();
        load_table();
        run_line(125);
        report("erase", e);
    endtask

    task automatic test_random();
        obj_pkg::obj_attr_t a;
        logic [15:0] v;
        int e;
        e = errors;
        for (int k = 0; k < 3; k++) begin
            clear_objs();
            for (int j = 0; j < 6; j++) begin
                a = '0;
                a.y = 8'(100 + obj_rand() % 16'd12);
                a.x = 9'(obj_rand() % 16'd480);
                v = obj_rand();
                a.size16 = v[15];
                a.hflip = v[14];
                a.vflip = v[13];
                a.pal = v[12:9];
                v = obj_rand();
                a.code = {v[11:0], 2'b00};
                set_obj(9 * j + 2, a);
            end
            load_table();
            run_line(110);
        end
        report("random", e);
    endtask

    initial begin
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_single();
        test_flips();
        test_overlap();
        test_erase();
        test_random();
        errors += UUT.u_scan.chk.assert_errors;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* obj_checker.sv */
`include "obj_cfg.svh"

module obj_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        done,
    input  logic                        line_start,
    input  logic                        rom_cs,
    input  logic                        rom_ok,
    input  logic [`OBJ_ROM_AW-1:0]      rom_addr,
    input  obj_pkg::line_wr_t           line_wr
);

    int assert_errors = 0;      // read by the testbench at the end

    no_write_when_done: assert property (@(posedge clk) disable iff (rst)
        done |-> !line_wr.we)
        else begin
            $error("line write while done is high");
            assert_errors++;
        end

    // a line start is the only thing allowed to drop a pending request
    cs_held: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !line_start |=> rom_cs)
        else begin
            $error("rom_cs dropped before rom_ok");
            assert_errors++;
        end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !line_start |=> $stable(rom_addr))
        else begin
            $error("rom_addr changed while waiting for rom_ok");
            assert_errors++;
        end

endmodule

bind obj_scan obj_checker chk (
    .clk        (clk),
    .rst        (rst),
    .done       (done),
    .line_start (line_start),
    .rom_cs     (rom_cs),
    .rom_ok     (rom_ok),
    .rom_addr   (rom_addr),
    .line_wr    (line_wr)
);

/* obj_top.sv */
`include "obj_cfg.svh"

module obj_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_we,
    input  logic [`OBJ_TABLE_AW-1:0]    cpu_addr,
    input  logic [7:0]                  cpu_din,
    input  logic                        lhbl,
    input  logic                        lvbl,
    input  logic [8:0]                  vrender,
    input  logic [`OBJ_LINE_AW-1:0]     hdump,
    input  logic                        pxl_cen,
    input  logic                        rom_ok,
    input  logic [15:0]                 rom_data,
    output logic                        done,
    output logic                        rom_cs,
    output logic [`OBJ_ROM_AW-1:0]      rom_addr,
    output logic [7:0]                  pxl
);

    logic [`OBJ_TABLE_AW-1:0]   scan_addr;
    logic [7:0]                 scan_data;
    obj_pkg::line_wr_t          line_wr;
    logic                       draw_half;

    obj_ram u_ram (
        .clk        (clk),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_din    (cpu_din),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .vrender    (vrender),
        .done       (done),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .line_wr    (line_wr),
        .draw_half  (draw_half)
    );

    obj_line_buffer u_line (
        .clk        (clk),
        .line_wr    (line_wr),
        .draw_half  (draw_half),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .pxl        (pxl)
    );

endmodule

/* obj_line_buffer.sv */
`include "obj_cfg.svh"

module obj_line_buffer (
    input  logic                        clk,
    input  obj_pkg::line_wr_t           line_wr,
    input  logic                        draw_half,
    input  logic                        pxl_cen,
    input  logic [`OBJ_LINE_AW-1:0]     hdump,
    output logic [7:0]                  pxl
);

    localparam int DEPTH = 2 ** (`OBJ_LINE_AW + 1);

    logic [7:0]             mem [DEPTH];
    logic [`OBJ_LINE_AW:0]  rd_addr;
    logic                   opaque;

    // display side always reads the half not being drawn
    assign rd_addr = {~draw_half, hdump};

    // pixel index 0 lets earlier objects show through
    assign opaque = line_wr.data[3:0] != 4'd0;

    always_ff @(posedge clk) begin
        if (line_wr.we && opaque) begin
            mem[line_wr.addr] <= line_wr.data;
        end
        if (pxl_cen) begin
            pxl          <= mem[rd_addr];
            mem[rd_addr] <= 8'd0;   // erased for the next draw pass
        end
    end

endmodule

/* obj_scan.sv */
`include "obj_cfg.svh"

module obj_scan (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lhbl,
    input  logic                        lvbl,
    input  logic [8:0]                  vrender,
    output logic                        done,
    output logic [`OBJ_TABLE_AW-1:0]    scan_addr,
    input  logic [7:0]                  scan_data,
    output logic                        rom_cs,
    output logic [`OBJ_ROM_AW-1:0]      rom_addr,
    input  logic                        rom_ok,
    input  logic [15:0]                 rom_data,
    output obj_pkg::line_wr_t           line_wr,
    output logic                        draw_half
);

    localparam int TW = `OBJ_TABLE_AW;
    localparam int LW = `OBJ_LINE_AW;
    localparam logic [TW-1:0] LAST_BASE = TW'(5 * (`OBJ_COUNT - 1));
    localparam logic [LW-1:0] X_OFFSET  = LW'(`OBJ_X_OFFSET);

    obj_pkg::scan_state_e   st;
    obj_pkg::obj_attr_t     attr;

    logic [TW-1:0]  base;           // first byte of the current entry
    logic [2:0]     byte_sel;
    logic           last_lhbl;
    logic           line_start;
    logic [8:0]     vdiff;
    logic           covered;
    logic [3:0]     row;            // already flipped
    logic [1:0]     word;           // ROM word inside the row
    logic           last_word;
    logic           x_load;         // x[7:0] arrives this cycle
    logic [15:0]    pxl_data;
    logic [1:0]     pxl_cnt;
    logic [LW-1:0]  xpos;
    logic [LW-1:0]  x_src;
    logic [LW-1:0]  x_span;
    logic [LW-1:0]  x_first;
    logic [13:0]    rom_code;
    logic           wr_we;
    logic [LW:0]    wr_addr;
    logic [7:0]     wr_data;

    assign line_start = lhbl && !last_lhbl && lvbl;

    // table byte addressed in each read state
    always_comb begin
        case (st)
            obj_pkg::read_y:    byte_sel = 3'd1;
            obj_pkg::read_code: byte_sel = 3'd2;
            obj_pkg::read_pal:  byte_sel = 3'd3;
            obj_pkg::read_x:    byte_sel = 3'd4;
            default:            byte_sel = 3'd0;
        endcase
    end

    assign scan_addr = base + TW'(byte_sel);

    assign vdiff   = vrender - {1'b0, attr.y};
    assign covered = (vrender >= {1'b0, attr.y}) &&
                     (vdiff < (attr.size16 ? 9'd16 : 9'd8));

    // 16 pixel objects take row bit 3 and column bit 3 as code bits 1 and 0
    assign rom_code = attr.size16 ? {attr.code[13:2], row[3], word[1]} : attr.code;
    assign rom_addr = {rom_code, row[2:0], word[0]};

    // first screen column, the right edge when mirrored
    assign x_src   = x_load ? {attr.x[LW-1], scan_data} : attr.x;
    assign x_span  = attr.size16 ? LW'(15) : LW'(7);
    assign x_first = x_src + X_OFFSET + (attr.hflip ? x_span : '0);

    assign line_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= obj_pkg::idle;
            done      <= 1'b1;
            rom_cs    <= 1'b0;
            draw_half <= 1'b0;
            last_lhbl <= 1'b0;
            base      <= '0;
            x_load    <= 1'b0;
            pxl_cnt   <= 2'd0;
            wr_we     <= 1'b0;
        end else begin
            last_lhbl <= lhbl;
            wr_we     <= 1'b0;
            if (line_start) begin           // restarts any scan in progress
                st        <= obj_pkg::read_size;
                done      <= 1'b0;
                rom_cs    <= 1'b0;
                draw_half <= ~draw_half;
                base      <= '0;
                x_load    <= 1'b0;
            end else begin
                case (st)
                    obj_pkg::read_size: st <= obj_pkg::read_y;
                    obj_pkg::read_y:    st <= obj_pkg::read_code;
                    obj_pkg::read_code: st <= obj_pkg::read_pal;
                    obj_pkg::read_pal: begin
                        st <= covered ? obj_pkg::read_x : obj_pkg::next_obj;
                    end
                    obj_pkg::read_x: begin
                        rom_cs <= 1'b1;     // code complete on this edge
                        x_load <= 1'b1;
                        st     <= obj_pkg::rom_wait;
                    end
                    obj_pkg::rom_wait: begin
                        x_load <= 1'b0;
                        if (rom_ok) begin
                            rom_cs  <= 1'b0;
                            pxl_cnt <= 2'd3;
                            st      <= obj_pkg::dump;
                        end
                    end
                    obj_pkg::dump: begin
                        wr_we   <= 1'b1;
                        pxl_cnt <= pxl_cnt - 2'd1;
                        if (pxl_cnt == 2'd0) begin
                            st <= obj_pkg::next_word;
                        end
                    end
                    obj_pkg::next_word: begin
                        if (last_word) begin
                            st <= obj_pkg::next_obj;
                        end else begin
                            rom_cs <= 1'b1;
                            st     <= obj_pkg::rom_wait;
                        end
                    end
                    obj_pkg::next_obj: begin
                        if (base == LAST_BASE) begin
                            done <= 1'b1;
                            st   <= obj_pkg::idle;
                        end else begin
                            base <= base + TW'(5);
                            st   <= obj_pkg::read_size;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // attribute decode and pixel datapath
    always_ff @(posedge clk) begin
        case (st)
            obj_pkg::read_y: begin          // byte 0 on the read port
                attr.x[LW-1]     <= scan_data[0];
                attr.size16      <= scan_data[1];
                attr.hflip       <= scan_data[4];
                attr.vflip       <= scan_data[5];
                attr.code[13:12] <= scan_data[7:6];
                attr.code[1:0]   <= 2'b00;
            end
            obj_pkg::read_code: begin
                attr.y <= scan_data;
            end
            obj_pkg::read_pal: begin
                attr.code[9:2] <= scan_data;
                row            <= vdiff[3:0] ^ {4{attr.vflip}};
                word           <= 2'd0;
            end
            obj_pkg::read_x: begin
                attr.code[11:10] <= scan_data[1:0];
                attr.pal         <= scan_data[7:4];
            end
            obj_pkg::rom_wait: begin
                if (x_load) begin
                    attr.x[LW-2:0] <= scan_data;
                end
                if (rom_ok) begin
                    pxl_data  <= rom_data;
                    word      <= word + 2'd1;   // next address while dumping
                    last_word <= (word == (attr.size16 ? 2'd3 : 2'd1));
                    if (word == 2'd0) begin
                        xpos <= x_first;
                    end
                end
            end
            obj_pkg::dump: begin            // msb nibble first
                wr_addr  <= {draw_half, xpos};
                wr_data  <= {attr.pal, pxl_data[15:12]};
                pxl_data <= pxl_data << 4;
                xpos     <= attr.hflip ? xpos - 1'b1 : xpos + 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* obj_ram.sv */
`include "obj_cfg.svh"

module obj_ram (
    input  logic                        clk,
    input  logic                        cpu_we,
    input  logic [`OBJ_TABLE_AW-1:0]    cpu_addr,
    input  logic [7:0]                  cpu_din,
    input  logic [`OBJ_TABLE_AW-1:0]    scan_addr,
    output logic [7:0]                  scan_data
);

    localparam int DEPTH = 5 * `OBJ_COUNT;

    logic [7:0] mem [DEPTH];
    logic       cpu_in_range;

    // addresses past the last entry are dropped
    assign cpu_in_range = cpu_addr < `OBJ_TABLE_AW'(DEPTH);

    always_ff @(posedge clk) begin
        if (cpu_we && cpu_in_range) begin
            mem[cpu_addr] <= cpu_din;
        end
    end

    // scanner side, one cycle read latency
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

endmodule

/* obj_pkg.sv */
`include "obj_cfg.svh"

package obj_pkg;

    // scanner states, named after the table byte being addressed
    typedef enum logic [3:0] {
        idle,
        read_size,
        read_y,
        read_code,
        read_pal,
        read_x,
        rom_wait,
        dump,
        next_word,
        next_obj
    } scan_state_e;

    typedef struct packed {
        logic [7:0]                 y;
        logic [`OBJ_LINE_AW-1:0]    x;
        logic                       size16;     // 16x16 when set, else 8x8
        logic                       hflip;
        logic                       vflip;
        logic [13:0]                code;       // bits 1:0 come from row and column
        logic [3:0]                 pal;
    } obj_attr_t;

    typedef struct packed {
        logic                       we;
        logic [`OBJ_LINE_AW:0]      addr;       // half select on top of x
        logic [7:0]                 data;       // palette and pixel index
    } line_wr_t;

endpackage

/* obj_cfg.svh */
`ifndef OBJ_CFG_SVH
`define OBJ_CFG_SVH

// attribute table
`define OBJ_COUNT       64      // entries, five bytes each
`define OBJ_TABLE_AW    9       // byte address into the table

// line buffer
`define OBJ_LINE_AW     9       // horizontal position

// graphics ROM, tile code + row + half-word
`define OBJ_ROM_AW      18

// screen column added to every object x
`define OBJ_X_OFFSET    8

`endif
